/* hdl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Datapath and channel file geometry
`define FETCH_DATA_WIDTH 16
`define FETCH_N_CHANNELS 16
`define FETCH_CHAN_BITS 4

// Per-channel count of writes still in flight
`define FETCH_PEND_BITS 4

`define FETCH_OP_BITS 5
`define FETCH_COMMIT_BITS 9

// Constant sources, valid when src_reg is set
`define FETCH_SRC_QUARTER 3
`define FETCH_SRC_HALF 4

`endif

/* hdl/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

	typedef logic signed [`FETCH_DATA_WIDTH - 1 : 0] data_t;
	typedef logic [`FETCH_CHAN_BITS - 1 : 0] chan_t;
	typedef logic [`FETCH_COMMIT_BITS - 1 : 0] commit_t;

	// Where one operand is fetched from
	typedef struct packed {
		chan_t src;                   // Channel, register or constant code
		logic src_reg;                // Register or constant instead of channel
		logic arg_needed;
	} operand_sel_t;

	// Instruction as it moves from slot to slot, index 0 is operand a
	typedef struct packed {
		logic [`FETCH_OP_BITS - 1 : 0] operation;
		chan_t dest;
		logic writes_channel;
		data_t register_0;
		data_t register_1;
		operand_sel_t [2 : 0] sel;
		data_t [2 : 0] arg;           // Filled in by the owning slot
	} fetch_instr_t;

	typedef struct packed {
		logic [`FETCH_OP_BITS - 1 : 0] operation;
		chan_t dest;
		logic writes_channel;
		data_t arg_a;
		data_t arg_b;
		data_t arg_c;
		commit_t commit_id;
	} fetch_result_t;

endpackage

/* hdl/fetch_if.sv */
interface fetch_if import fetch_pkg::*; ();

	logic valid;
	logic ready;
	fetch_instr_t instr;

	// Transfer when valid and ready are both high
	modport source (
		output valid,
		output instr,
		input ready
	);

	modport sink (
		input valid,
		input instr,
		output ready
	);

endinterface

/* hdl/channel_file.sv */
`include "fetch_consts.svh"

module channel_file import fetch_pkg::*; (
	input logic clk,
	input logic reset,

	input logic write_enable,
	input chan_t write_addr,
	input data_t write_val,

	input chan_t read_addr_a,
	input chan_t read_addr_b,
	input chan_t read_addr_c,
	output data_t read_val_a,
	output data_t read_val_b,
	output data_t read_val_c
);

	data_t channels [`FETCH_N_CHANNELS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `FETCH_N_CHANNELS; i++) begin
				channels[i] <= '0;
			end
		end else if (write_enable) begin
			channels[write_addr] <= write_val;
		end
	end

	// One read port per operand slot
	assign read_val_a = channels[read_addr_a];
	assign read_val_b = channels[read_addr_b];
	assign read_val_c = channels[read_addr_c];

endmodule

/* hdl/operand_slot.sv */
`include "fetch_consts.svh"

module operand_slot import fetch_pkg::*; #(
	parameter int slot_index = 0,
	parameter bit assigns_commit = 1'b0
) (
	input logic clk,
	input logic reset,

	fetch_if.sink up,
	fetch_if.source down,

	output logic res_valid,
	input logic res_ready,
	output fetch_result_t res,

	output chan_t read_addr,
	input data_t read_val,

	input logic write_enable,
	input chan_t write_addr,
	input data_t write_val
);

	logic [`FETCH_PEND_BITS - 1 : 0] pend [`FETCH_N_CHANNELS];
	logic [`FETCH_PEND_BITS - 1 : 0] pend_next [`FETCH_N_CHANNELS];
	logic [`FETCH_N_CHANNELS - 1 : 0] busy_bits;

	logic busy;                       // Instruction parked in hold
	fetch_instr_t hold;

	logic out_valid;
	fetch_instr_t out_instr;
	commit_t out_commit;
	commit_t commit_count;

	fetch_instr_t live;
	fetch_instr_t next_instr;
	operand_sel_t sel;
	data_t reg_value;
	data_t fetched;

	logic forward_hit;
	logic needs_stall;
	logic out_ready;
	logic out_free;
	logic take;
	logic latch;
	logic load_out;
	logic adds_pending;

	assign live = busy ? hold : up.instr;
	assign sel = live.sel[slot_index];
	assign read_addr = sel.src;

	// Last awaited write lands this cycle
	assign forward_hit = write_enable && write_addr == sel.src && pend[sel.src] == 1;
	assign needs_stall = sel.arg_needed && !sel.src_reg && busy_bits[sel.src] && !forward_hit;

	always_comb begin
		case (sel.src)
			0: reg_value = live.register_0;
			1: reg_value = live.register_1;
			`FETCH_SRC_QUARTER: reg_value = data_t'(1) << (`FETCH_DATA_WIDTH - 2);
			`FETCH_SRC_HALF: reg_value = data_t'(1) << (`FETCH_DATA_WIDTH - 1);
			default: reg_value = '0;
		endcase
	end

	always_comb begin
		if (!sel.arg_needed)
			fetched = '0;
		else if (sel.src_reg)
			fetched = reg_value;
		else if (busy_bits[sel.src])
			fetched = write_val;          // Only taken on a forward hit
		else
			fetched = read_val;
	end

	always_comb begin
		next_instr = live;
		next_instr.arg[slot_index] = fetched;
	end

	assign out_ready = assigns_commit ? res_ready : down.ready;
	assign out_free = !out_valid || out_ready;
	assign up.ready = !busy && out_free;

	assign take = up.valid && up.ready;
	assign latch = take && needs_stall;
	assign load_out = busy ? (!needs_stall && out_free) : (take && !needs_stall);
	assign adds_pending = load_out && live.writes_channel;

	// Scoreboard counts writes from instructions already past this slot
	always_comb begin
		for (int i = 0; i < `FETCH_N_CHANNELS; i++) begin
			pend_next[i] = pend[i];
			if (adds_pending && live.dest == chan_t'(i))
				pend_next[i] = pend_next[i] + 1'b1;
			if (write_enable && write_addr == chan_t'(i) && pend[i] != '0)
				pend_next[i] = pend_next[i] - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pend <= '{default: '0};
			busy_bits <= '0;
			busy <= 1'b0;
			out_valid <= 1'b0;
			commit_count <= '0;
		end else begin
			pend <= pend_next;
			for (int i = 0; i < `FETCH_N_CHANNELS; i++) begin
				busy_bits[i] <= pend_next[i] != '0;
			end

			if (latch)
				busy <= 1'b1;
			else if (load_out)
				busy <= 1'b0;

			if (load_out)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;

			if (assigns_commit && adds_pending)
				commit_count <= commit_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (latch)
			hold <= up.instr;

		if (load_out) begin
			out_instr <= next_instr;
			out_commit <= commit_count;   // Non-writers do not consume an id
		end
	end

	assign down.valid = out_valid;
	assign down.instr = out_instr;

	assign res_valid = out_valid;
	assign res = '{
		operation: out_instr.operation,
		dest: out_instr.dest,
		writes_channel: out_instr.writes_channel,
		arg_a: out_instr.arg[0],
		arg_b: out_instr.arg[1],
		arg_c: out_instr.arg[2],
		commit_id: out_commit
	};

endmodule

/* hdl/skid_buffer.sv */
module skid_buffer import fetch_pkg::*; (
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input fetch_result_t in_res,

	output logic out_valid,
	input logic out_ready,
	output fetch_result_t out_res
);

	fetch_result_t entries [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1 : 0] count;

	logic empty;
	logic push;
	logic pop;

	assign empty = count == 2'd0;
	assign in_ready = count != 2'd2;

	// Falls through when empty
	assign out_valid = !empty || in_valid;
	assign out_res = empty ? in_res : entries[rd_ptr];

	assign push = in_valid && in_ready && !(empty && out_ready);
	assign pop = !empty && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;

			case ({push, pop})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= in_res;
	end

endmodule

/* hdl/operand_fetch_stage.sv */
`include "fetch_consts.svh"

module operand_fetch_stage import fetch_pkg::*; (
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input logic [`FETCH_OP_BITS - 1 : 0] operation_in,
	input chan_t dest_in,
	input logic writes_channel_in,
	input data_t register_0_in,
	input data_t register_1_in,
	input chan_t src_a_in,
	input chan_t src_b_in,
	input chan_t src_c_in,
	input logic src_a_reg_in,
	input logic src_b_reg_in,
	input logic src_c_reg_in,
	input logic arg_a_needed_in,
	input logic arg_b_needed_in,
	input logic arg_c_needed_in,

	output logic out_valid,
	input logic out_ready,
	output logic [`FETCH_OP_BITS - 1 : 0] operation_out,
	output chan_t dest_out,
	output logic writes_channel_out,
	output data_t arg_a_out,
	output data_t arg_b_out,
	output data_t arg_c_out,
	output commit_t commit_id_out,

	input logic channel_write_enable,
	input chan_t channel_write_addr,
	input data_t channel_write_val
);

	fetch_if head_if ();
	fetch_if ab_if ();
	fetch_if bc_if ();
	fetch_if tail_if ();              // Slot c hands off through res instead

	chan_t read_addr_a;
	chan_t read_addr_b;
	chan_t read_addr_c;
	data_t read_val_a;
	data_t read_val_b;
	data_t read_val_c;

	logic res_valid;
	logic skid_ready;
	fetch_result_t slot_res;
	fetch_result_t out_res;

	assign head_if.valid = in_valid;
	assign in_ready = head_if.ready;
	assign head_if.instr = '{
		operation: operation_in,
		dest: dest_in,
		writes_channel: writes_channel_in,
		register_0: register_0_in,
		register_1: register_1_in,
		sel: '{
			'{src_c_in, src_c_reg_in, arg_c_needed_in},
			'{src_b_in, src_b_reg_in, arg_b_needed_in},
			'{src_a_in, src_a_reg_in, arg_a_needed_in}
		},
		arg: '0
	};

	assign tail_if.ready = 1'b0;

	channel_file i_channels (
		.clk(clk),
		.reset(reset),
		.write_enable(channel_write_enable),
		.write_addr(channel_write_addr),
		.write_val(channel_write_val),
		.read_addr_a(read_addr_a),
		.read_addr_b(read_addr_b),
		.read_addr_c(read_addr_c),
		.read_val_a(read_val_a),
		.read_val_b(read_val_b),
		.read_val_c(read_val_c)
	);

	operand_slot #(.slot_index(0), .assigns_commit(1'b0)) i_slot_a (
		.clk(clk),
		.reset(reset),
		.up(head_if),
		.down(ab_if),
		.res_valid(),
		.res_ready(1'b0),
		.res(),
		.read_addr(read_addr_a),
		.read_val(read_val_a),
		.write_enable(channel_write_enable),
		.write_addr(channel_write_addr),
		.write_val(channel_write_val)
	);

	operand_slot #(.slot_index(1), .assigns_commit(1'b0)) i_slot_b (
		.clk(clk),
		.reset(reset),
		.up(ab_if),
		.down(bc_if),
		.res_valid(),
		.res_ready(1'b0),
		.res(),
		.read_addr(read_addr_b),
		.read_val(read_val_b),
		.write_enable(channel_write_enable),
		.write_addr(channel_write_addr),
		.write_val(channel_write_val)
	);

	operand_slot #(.slot_index(2), .assigns_commit(1'b1)) i_slot_c (
		.clk(clk),
		.reset(reset),
		.up(bc_if),
		.down(tail_if),
		.res_valid(res_valid),
		.res_ready(skid_ready),
		.res(slot_res),
		.read_addr(read_addr_c),
		.read_val(read_val_c),
		.write_enable(channel_write_enable),
		.write_addr(channel_write_addr),
		.write_val(channel_write_val)
	);

	skid_buffer i_skid (
		.clk(clk),
		.reset(reset),
		.in_valid(res_valid),
		.in_ready(skid_ready),
		.in_res(slot_res),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res(out_res)
	);

	assign operation_out = out_res.operation;
	assign dest_out = out_res.dest;
	assign writes_channel_out = out_res.writes_channel;
	assign arg_a_out = out_res.arg_a;
	assign arg_b_out = out_res.arg_b;
	assign arg_c_out = out_res.arg_c;
	assign commit_id_out = out_res.commit_id;

endmodule

/* verification/fetch_checker.sv */
module fetch_checker import fetch_pkg::*; #(
	parameter int n_rows = 1,
	parameter int n_results = 1,
	parameter int timeout_cycles = 200
) (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic out_ready,
	input logic [4 : 0] operation_out,
	input chan_t dest_out,
	input logic writes_channel_out,
	input data_t arg_a_out,
	input data_t arg_b_out,
	input data_t arg_c_out,
	input commit_t commit_id_out,
	output int errors,
	output int checked
);

	data_t model [16];                // Channels as program order leaves them
	commit_t next_commit;
	int idle;

	function automatic data_t expected_arg(input int r, input int k);
		chan_t src;
		src = k == 0 ? operand_fetch_tb.rows[r].src_a :
			k == 1 ? operand_fetch_tb.rows[r].src_b : operand_fetch_tb.rows[r].src_c;
		if (!operand_fetch_tb.rows[r].needed[k])
			return '0;
		if (!operand_fetch_tb.rows[r].is_reg[k])
			return model[src];
		case (src)
			4'd0: return operand_fetch_tb.rows[r].reg_0;
			4'd1: return operand_fetch_tb.rows[r].reg_1;
			4'd3: return 16'h4000;        // Quarter scale
			4'd4: return 16'h8000;        // Half scale, most negative
			default: return '0;
		endcase
	endfunction

	task automatic compare_field(input string name, input logic [31 : 0] got,
		input logic [31 : 0] exp);
		if (got !== exp) begin
			$display("** Error result %0d %s: got %0h, expected %0h", checked, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_result();
		int r;
		r = checked % n_rows;
		compare_field("operation_out", operation_out, r % 32);
		compare_field("dest_out", dest_out, operand_fetch_tb.rows[r].dest);
		compare_field("writes_channel_out", writes_channel_out, operand_fetch_tb.rows[r].writes);
		compare_field("arg_a_out", arg_a_out, expected_arg(r, 0));
		compare_field("arg_b_out", arg_b_out, expected_arg(r, 1));
		compare_field("arg_c_out", arg_c_out, expected_arg(r, 2));
		if (operand_fetch_tb.rows[r].writes) begin
			compare_field("commit_id_out", commit_id_out, next_commit);
			next_commit = next_commit + 1'b1;
			// Write becomes visible to later instructions only
			model[operand_fetch_tb.rows[r].dest] = operand_fetch_tb.rows[r].result
				+ data_t'(checked / n_rows);
		end
		checked++;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			errors = 0;
			checked = 0;
			idle = 0;
			next_commit = '0;
			model = '{default: '0};
		end else if (out_valid && out_ready) begin
			check_result();
			idle = 0;
		end else if (checked < n_results) begin
			idle++;
			if (idle == timeout_cycles) begin
				$display("No result for %0d cycles after %0d results", idle, checked);
				errors++;
			end
		end
	end

endmodule

/* verification/fetch_assert.sv */
module fetch_assert import fetch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic out_ready,
	input logic [4 : 0] operation_out,
	input chan_t dest_out,
	input logic writes_channel_out,
	input data_t arg_a_out,
	input data_t arg_b_out,
	input data_t arg_c_out,
	input commit_t commit_id_out
);

	int failures = 0;

	// A stalled result must not move
	hold_result: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable({operation_out, dest_out,
			writes_channel_out, arg_a_out, arg_b_out, arg_c_out, commit_id_out}))
	else begin
		failures++;
		$error("Result or out_valid changed while out_ready was low");
	end

	low_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
	else begin
		failures++;
		$error("out_valid high in the cycle after reset");
	end

endmodule

bind operand_fetch_stage fetch_assert i_assert (.*);

/* verification/operand_fetch_tb.sv */
module operand_fetch_tb import fetch_pkg::*; ();

	localparam int n_rows = 14;
	localparam int n_passes = 3;
	localparam int n_results = n_rows * n_passes;
	localparam int timeout_cycles = 200;

	typedef struct packed {
		chan_t src_a;
		chan_t src_b;
		chan_t src_c;
		logic [2 : 0] is_reg;         // Bit 0 is operand a
		logic [2 : 0] needed;
		data_t reg_0;
		data_t reg_1;
		chan_t dest;
		logic writes;
		data_t result;
	} row_t;

	typedef struct {
		chan_t dest;
		data_t value;
		int delay;
	} writeback_t;

	logic clk = 1'b0;
	logic reset, in_valid, in_ready, out_valid, out_ready;
	logic [4 : 0] operation_in, operation_out;
	chan_t dest_in, dest_out, src_a_in, src_b_in, src_c_in, channel_write_addr;
	logic writes_channel_in, writes_channel_out, channel_write_enable;
	logic src_a_reg_in, src_b_reg_in, src_c_reg_in;
	logic arg_a_needed_in, arg_b_needed_in, arg_c_needed_in;
	data_t register_0_in, register_1_in, channel_write_val;
	data_t arg_a_out, arg_b_out, arg_c_out;
	commit_t commit_id_out;
	int errors, checked;

	int seed = 32'h520d;
	int out_count = 0;
	writeback_t wb_queue [$];

	// Operation of each instruction is its row index
	row_t rows [n_rows] = '{
		'{4'd0, 4'd1, 4'd3, 3'b111, 3'b111, 16'h1234, 16'habcd, 4'd1, 1'b1, 16'h0101},
		'{4'd4, 4'd2, 4'd5, 3'b011, 3'b011, 16'h5555, 16'h6666, 4'd2, 1'b0, 16'h0000},
		'{4'd1, 4'd1, 4'd0, 3'b000, 3'b111, 16'h0000, 16'h0000, 4'd2, 1'b1, 16'h0202},
		'{4'd2, 4'd0, 4'd1, 3'b010, 3'b111, 16'h7777, 16'h0000, 4'd2, 1'b1, 16'h0303},
		'{4'd2, 4'd2, 4'd2, 3'b000, 3'b111, 16'h0000, 16'h0000, 4'd3, 1'b1, 16'h0404},
		'{4'd3, 4'd7, 4'd15, 3'b100, 3'b111, 16'h1111, 16'h2222, 4'd3, 1'b0, 16'h0000},
		'{4'd3, 4'd2, 4'd1, 3'b000, 3'b111, 16'h0000, 16'h0000, 4'd3, 1'b1, 16'h0606},
		'{4'd3, 4'd3, 4'd1, 3'b100, 3'b111, 16'h0000, 16'hbeef, 4'd4, 1'b1, 16'h0707},
		'{4'd4, 4'd4, 4'd3, 3'b000, 3'b111, 16'h0000, 16'h0000, 4'd4, 1'b1, 16'h0808},
		'{4'd4, 4'd1, 4'd4, 3'b110, 3'b111, 16'h0000, 16'h3333, 4'd5, 1'b0, 16'h0000},
		'{4'd4, 4'd9, 4'd1, 3'b000, 3'b111, 16'h0000, 16'h0000, 4'd9, 1'b1, 16'h0a0a},
		'{4'd9, 4'd9, 4'd9, 3'b000, 3'b101, 16'h0000, 16'h0000, 4'd9, 1'b1, 16'h0b0b},
		'{4'd9, 4'd0, 4'd0, 3'b110, 3'b001, 16'h4444, 16'h0000, 4'd0, 1'b1, 16'h8c0c},
		'{4'd0, 4'd9, 4'd4, 3'b000, 3'b111, 16'h0000, 16'h0000, 4'd6, 1'b0, 16'h0000}
	};

	operand_fetch_stage i_dut (.*);

	fetch_checker #(.n_rows(n_rows), .n_results(n_results), .timeout_cycles(timeout_cycles))
		i_checker (.*);

	always #4 clk = !clk;

	task automatic drive_row(input row_t row, input int index);
		operation_in = index[4 : 0];
		dest_in = row.dest;
		writes_channel_in = row.writes;
		register_0_in = row.reg_0;
		register_1_in = row.reg_1;
		src_a_in = row.src_a;
		src_b_in = row.src_b;
		src_c_in = row.src_c;
		src_a_reg_in = row.is_reg[0];
		src_b_reg_in = row.is_reg[1];
		src_c_reg_in = row.is_reg[2];
		arg_a_needed_in = row.needed[0];
		arg_b_needed_in = row.needed[1];
		arg_c_needed_in = row.needed[2];
	endtask

	// Each pass adds its number to the written values
	always @(posedge clk) begin
		writeback_t wb;
		if (!reset && out_valid && out_ready) begin
			if (rows[out_count % n_rows].writes) begin
				wb.dest = rows[out_count % n_rows].dest;
				wb.value = rows[out_count % n_rows].result + data_t'(out_count / n_rows);
				wb.delay = $unsigned($random(seed)) % 7;
				wb_queue.push_back(wb);
			end
			out_count++;
		end
	end

	// Writeback side, one channel write per cycle in result order
	initial begin
		channel_write_enable = 1'b0;
		channel_write_addr = '0;
		channel_write_val = '0;
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			channel_write_enable = 1'b0;
			out_ready = ($random(seed) & 3) != 0;
			if (wb_queue.size() != 0) begin
				if (wb_queue[0].delay == 0) begin
					channel_write_enable = 1'b1;
					channel_write_addr = wb_queue[0].dest;
					channel_write_val = wb_queue[0].value;
					void'(wb_queue.pop_front());
				end else begin
					wb_queue[0].delay = wb_queue[0].delay - 1;
				end
			end
		end
	end

	initial begin
		int t;
		bit accepted;
		bit stuck;
		reset = 1'b1;
		in_valid = 1'b0;
		drive_row('0, 0);
		stuck = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int n = 0; n < n_results && !stuck; n++) begin
			drive_row(rows[n % n_rows], n % n_rows);
			in_valid = 1'b1;
			t = 0;
			accepted = 1'b0;
			while (!accepted && t < timeout_cycles) begin
				@(negedge clk);
				accepted = in_ready;
				@(posedge clk);
				#1;
				t++;
			end
			stuck = !accepted;
		end
		in_valid = 1'b0;
		t = 0;
		while (checked < n_results && t < timeout_cycles) begin
			@(negedge clk);
			t++;
		end
		if (stuck)
			$display("Timeout: in_ready stayed low for %0d cycles", timeout_cycles);
		if (checked < n_results)
			$display("Timeout: only %0d of %0d results came out", checked, n_results);
		$display("Results checked %0d of %0d, value errors %0d, assertion failures %0d",
			checked, n_results, errors, i_dut.i_assert.failures);
		if (!stuck && checked == n_results && errors == 0 && i_dut.i_assert.failures == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/channel_file.sv
hdl/operand_slot.sv
hdl/skid_buffer.sv
hdl/operand_fetch_stage.sv
verification/fetch_checker.sv
verification/fetch_assert.sv
verification/operand_fetch_tb.sv

/* run.sh */
#!/bin/sh
set -e
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module operand_fetch_tb -o operand_fetch_sim
./obj_dir/operand_fetch_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -q "Regression failed" sim.log; then
	exit 1
fi
